//--- rename_pkg.sv
package rename_pkg;

    localparam int NUM_D_REG  = 32;  // Data physical registers.
    localparam int NUM_S_REG  = 16;  // Status physical registers.
    localparam int NUM_ARCH_D = 8;
    localparam int NUM_ARCH_S = 4;

    typedef logic [$clog2(NUM_D_REG)-1:0]  d_phys_t;
    typedef logic [$clog2(NUM_S_REG)-1:0]  s_phys_t;
    typedef logic [$clog2(NUM_ARCH_D)-1:0] d_arch_t;
    typedef logic [$clog2(NUM_ARCH_S)-1:0] s_arch_t;

    typedef struct packed {
        logic    valid;
        logic    use_rw;
        d_arch_t rw_arch;
        logic    use_rs;
        s_arch_t rs_arch;
        logic    unit;       // 0 is the ALU pipe, 1 the memory pipe.
    } dec_instr_t;

    typedef struct packed {
        d_phys_t new_rw;
        d_phys_t prev_rw;
        s_phys_t new_rs;
        s_phys_t prev_rs;
    } rename_out_t;

    // One-cycle return pulses, one bit per physical register.
    typedef struct packed {
        logic [NUM_D_REG-1:0] r_list;
        logic [NUM_S_REG-1:0] s_list;
    } reg_return_t;

endpackage

//--- rob_pkg.sv
package rob_pkg;

    localparam int ROB_SIZE = 16;

    typedef logic [$clog2(ROB_SIZE)-1:0] rob_addr_t;

    typedef struct packed {
        rob_addr_t high;     // Tail, first free slot.
        rob_addr_t low;      // Head, oldest entry.
        logic      empty;
    } rob_range_t;

    typedef struct packed {
        logic      valid;
        rob_addr_t rob_addr;
    } completion_t;

    // True when addr lies in [low, high) with wrap-around.
    function automatic logic rob_in_range(rob_range_t range, rob_addr_t addr);
        logic result;
        if (range.high > range.low) begin
            result = (addr >= range.low) && (addr < range.high);
        end else if (range.high == range.low) begin
            result = !range.empty;  // Equal pointers mean empty or full.
        end else begin
            result = (addr >= range.low) || (addr < range.high);
        end
        return result;
    endfunction

endpackage

//--- free_reg_list.sv
`timescale 1ns/1ps

module free_reg_list #(
    parameter type phys_t   = logic [4:0],
    parameter int  NUM      = 32,
    parameter int  NUM_ARCH = 8
) (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           alloc,
    output phys_t          free_addr,
    output logic           empty,
    input  logic [NUM-1:0] returns
);

    // Registers below NUM_ARCH hold the initial architectural mapping.
    localparam logic [NUM-1:0] RESET_MAP = {NUM{1'b1}} << NUM_ARCH;

    logic [NUM-1:0] bitmap;
    logic [NUM-1:0] bitmap_next;

    // Lowest set bit wins.
    always_comb begin
        free_addr = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (bitmap[i]) begin
                free_addr = phys_t'(i);
            end
        end
    end

    assign empty = ~|bitmap;

    always_comb begin
        bitmap_next = bitmap | returns;
        if (alloc && !empty) begin
            bitmap_next[free_addr] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            bitmap <= RESET_MAP;
        end else begin
            bitmap <= bitmap_next;
        end
    end

endmodule

//--- translation_table.sv
`timescale 1ns/1ps

module translation_table (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   push,
    input  rename_pkg::dec_instr_t instr,
    input  rename_pkg::d_phys_t    new_rw,
    input  rename_pkg::s_phys_t    new_rs,
    input  rob_pkg::rob_addr_t     slot,
    input  logic                   rollback,
    input  rob_pkg::rob_addr_t     restore_slot,
    output rename_pkg::d_phys_t    prev_rw,
    output rename_pkg::s_phys_t    prev_rs
);

    typedef struct packed {
        rename_pkg::d_phys_t [rename_pkg::NUM_ARCH_D-1:0] d;
        rename_pkg::s_phys_t [rename_pkg::NUM_ARCH_S-1:0] s;
    } map_t;

    map_t map;
    map_t checkpoint [rob_pkg::ROB_SIZE];

    assign prev_rw = map.d[instr.rw_arch];
    assign prev_rs = map.s[instr.rs_arch];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH_D; i++) begin
                map.d[i] <= rename_pkg::d_phys_t'(i);   // Identity map.
            end
            for (int i = 0; i < rename_pkg::NUM_ARCH_S; i++) begin
                map.s[i] <= rename_pkg::s_phys_t'(i);
            end
        end else if (rollback) begin
            map <= checkpoint[restore_slot];
        end else if (push) begin
            if (instr.use_rw) begin
                map.d[instr.rw_arch] <= new_rw;
            end
            if (instr.use_rs) begin
                map.s[instr.rs_arch] <= new_rs;
            end
        end
    end

    // Snapshot taken before the slot's own writes.
    always_ff @(posedge clk) begin
        if (push && !rollback) begin
            checkpoint[slot] <= map;
        end
    end

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    push,
    input  rename_pkg::rename_out_t rename_in,
    input  logic                    use_rw,
    input  logic                    use_rs,
    input  logic                    rollback,
    input  rob_pkg::rob_addr_t      incident_addr,
    input  rob_pkg::completion_t    completion,
    output rename_pkg::reg_return_t checkin,
    output rob_pkg::rob_range_t     active_range,
    output logic                    rob_full,
    output rob_pkg::rob_addr_t      rob_open_slot
);

    typedef struct packed {
        logic                    done;
        logic                    use_rw;
        logic                    use_rs;
        rename_pkg::rename_out_t regs;
    } rob_entry_t;

    rob_entry_t buffer [rob_pkg::ROB_SIZE];

    rob_pkg::rob_addr_t      head;
    rob_pkg::rob_addr_t      tail;
    rob_pkg::rob_addr_t      count;
    rob_pkg::rob_addr_t      squash_start;
    rob_pkg::rob_range_t     squash_range;
    logic                    empty;
    logic                    retire;
    rename_pkg::reg_return_t checkin_next;

    // At most ROB_SIZE-1 entries, so equal pointers always mean empty.
    assign count = tail - head;
    assign empty = (head == tail);
    assign rob_full = (count == rob_pkg::rob_addr_t'(rob_pkg::ROB_SIZE - 1));
    assign rob_open_slot = tail;

    assign active_range.high  = tail;
    assign active_range.low   = head;
    assign active_range.empty = empty;

    assign retire = buffer[head].done && !empty;

    // Slots from incident_addr+1 up to the tail are squashed.
    assign squash_start       = incident_addr + 1'b1;
    assign squash_range.low   = squash_start;
    assign squash_range.high  = tail;
    assign squash_range.empty = (squash_start == tail);

    always_comb begin
        checkin_next = '0;
        if (retire) begin
            if (buffer[head].use_rw) begin
                checkin_next.r_list[buffer[head].regs.prev_rw] = 1'b1;
            end
            if (buffer[head].use_rs) begin
                checkin_next.s_list[buffer[head].regs.prev_rs] = 1'b1;
            end
        end
        if (rollback) begin
            for (int i = 0; i < rob_pkg::ROB_SIZE; i++) begin
                if (rob_pkg::rob_in_range(squash_range, rob_pkg::rob_addr_t'(i))) begin
                    if (buffer[i].use_rw) begin
                        checkin_next.r_list[buffer[i].regs.new_rw] = 1'b1;
                    end
                    if (buffer[i].use_rs) begin
                        checkin_next.s_list[buffer[i].regs.new_rs] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head    <= '0;
            tail    <= '0;
            checkin <= '0;
        end else begin
            checkin <= checkin_next;
            if (retire) begin
                head <= head + 1'b1;
            end
            if (rollback) begin
                tail <= squash_start;
            end else if (push) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // Entry storage. A push at the tail overrides a stray done mark.
    always_ff @(posedge clk) begin
        if (completion.valid) begin
            buffer[completion.rob_addr].done <= 1'b1;
        end
        if (push && !rollback) begin
            buffer[tail] <= '{done: 1'b0, use_rw: use_rw, use_rs: use_rs, regs: rename_in};
        end
    end

endmodule

//--- exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe #(
    parameter int LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 issue,
    input  rob_pkg::rob_addr_t   issue_addr,
    input  rob_pkg::rob_range_t  active_range,
    input  logic                 grant,
    output logic                 ready_in,
    output rob_pkg::completion_t request
);

    logic [LATENCY-1:0] stage_valid;
    logic [LATENCY-1:0] live;
    logic               hold;
    rob_pkg::rob_addr_t stage_addr [LATENCY];

    // Squashed slots vanish here, before they can request.
    always_comb begin
        for (int i = 0; i < LATENCY; i++) begin
            live[i] = stage_valid[i] && rob_pkg::rob_in_range(active_range, stage_addr[i]);
        end
    end

    assign request.valid    = live[LATENCY-1];
    assign request.rob_addr = stage_addr[LATENCY-1];

    assign hold     = live[LATENCY-1] && !grant;   // Output stage not granted.
    assign ready_in = !hold || !live[0];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            stage_valid <= '0;
        end else begin
            for (int i = LATENCY - 1; i > 0; i--) begin
                stage_valid[i] <= hold ? live[i] : live[i-1];
            end
            stage_valid[0] <= issue || (hold && live[0]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = LATENCY - 1; i > 0; i--) begin
            if (!hold) begin
                stage_addr[i] <= stage_addr[i-1];
            end
        end
        if (issue) begin
            stage_addr[0] <= issue_addr;
        end
    end

endmodule

//--- completion_arbiter.sv
`timescale 1ns/1ps

module completion_arbiter (
    input  logic                 clk,
    input  logic                 n_rst,
    input  rob_pkg::completion_t alu_req,
    input  rob_pkg::completion_t mem_req,
    output logic                 alu_grant,
    output logic                 mem_grant,
    output rob_pkg::completion_t completion
);

    logic last_mem;   // Memory pipe won the last grant.

    assign alu_grant = alu_req.valid && (!mem_req.valid || last_mem);
    assign mem_grant = mem_req.valid && (!alu_req.valid || !last_mem);

    always_comb begin
        if (alu_grant) begin
            completion = alu_req;
        end else if (mem_grant) begin
            completion = mem_req;
        end else begin
            completion = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            last_mem <= 1'b1;   // ALU goes first on a tie.
        end else if (alu_grant) begin
            last_mem <= 1'b0;
        end else if (mem_grant) begin
            last_mem <= 1'b1;
        end
    end

endmodule

//--- rename_core.sv
`timescale 1ns/1ps

module rename_core #(
    parameter int ALU_LATENCY = 2,
    parameter int MEM_LATENCY = 4
) (
    input  logic                    clk,
    input  logic                    n_rst,
    input  rename_pkg::dec_instr_t  instr,
    input  logic                    rollback,
    input  rob_pkg::rob_addr_t      incident_addr,
    output logic                    stall,
    output rob_pkg::rob_addr_t      rob_open_slot,
    output rename_pkg::rename_out_t renamed,
    output rename_pkg::reg_return_t checkin,
    output rob_pkg::rob_range_t     active_range
);

    logic                 push;
    logic                 rob_full;
    logic                 d_empty;
    logic                 s_empty;
    logic                 alu_ready;
    logic                 mem_ready;
    logic                 alu_grant;
    logic                 mem_grant;
    logic                 tt_rollback;
    rob_pkg::rob_addr_t   restore_slot;
    rob_pkg::completion_t alu_req;
    rob_pkg::completion_t mem_req;
    rob_pkg::completion_t completion;

    always_comb begin
        stall = rob_full;
        if (instr.valid) begin
            stall = stall || (instr.use_rw && d_empty) || (instr.use_rs && s_empty);
            stall = stall || (instr.unit ? !mem_ready : !alu_ready);
        end
    end

    assign push = instr.valid && !stall && !rollback;

    // No checkpoint to restore when nothing younger than the incident exists.
    assign restore_slot = incident_addr + 1'b1;
    assign tt_rollback  = rollback && rob_pkg::rob_in_range(active_range, restore_slot);

    free_reg_list #(
        .phys_t   (rename_pkg::d_phys_t),
        .NUM      (rename_pkg::NUM_D_REG),
        .NUM_ARCH (rename_pkg::NUM_ARCH_D)
    ) d_frl_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .alloc     (push && instr.use_rw),
        .free_addr (renamed.new_rw),
        .empty     (d_empty),
        .returns   (checkin.r_list)
    );

    free_reg_list #(
        .phys_t   (rename_pkg::s_phys_t),
        .NUM      (rename_pkg::NUM_S_REG),
        .NUM_ARCH (rename_pkg::NUM_ARCH_S)
    ) s_frl_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .alloc     (push && instr.use_rs),
        .free_addr (renamed.new_rs),
        .empty     (s_empty),
        .returns   (checkin.s_list)
    );

    translation_table tt_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .push         (push),
        .instr        (instr),
        .new_rw       (renamed.new_rw),
        .new_rs       (renamed.new_rs),
        .slot         (rob_open_slot),
        .rollback     (tt_rollback),
        .restore_slot (restore_slot),
        .prev_rw      (renamed.prev_rw),
        .prev_rs      (renamed.prev_rs)
    );

    reorder_buffer rob_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .push          (push),
        .rename_in     (renamed),
        .use_rw        (instr.use_rw),
        .use_rs        (instr.use_rs),
        .rollback      (rollback),
        .incident_addr (incident_addr),
        .completion    (completion),
        .checkin       (checkin),
        .active_range  (active_range),
        .rob_full      (rob_full),
        .rob_open_slot (rob_open_slot)
    );

    exec_pipe #(.LATENCY(ALU_LATENCY)) alu_pipe_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .issue        (push && !instr.unit),
        .issue_addr   (rob_open_slot),
        .active_range (active_range),
        .grant        (alu_grant),
        .ready_in     (alu_ready),
        .request      (alu_req)
    );

    exec_pipe #(.LATENCY(MEM_LATENCY)) mem_pipe_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .issue        (push && instr.unit),
        .issue_addr   (rob_open_slot),
        .active_range (active_range),
        .grant        (mem_grant),
        .ready_in     (mem_ready),
        .request      (mem_req)
    );

    completion_arbiter arb_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .alu_req    (alu_req),
        .mem_req    (mem_req),
        .alu_grant  (alu_grant),
        .mem_grant  (mem_grant),
        .completion (completion)
    );

endmodule

//--- rename_checker.sv
`timescale 1ns/1ps

module rename_checker (
    input logic                 clk,
    input logic                 n_rst,
    input logic                 rollback,
    input logic                 rob_full,
    input logic                 empty,
    input rob_pkg::rob_addr_t   count,
    input rob_pkg::completion_t completion,
    input rob_pkg::rob_range_t  active_range
);

    int fail_count = 0;

    // A push into a full buffer would wrap the tail onto the head.
    full_and_empty: assert property (@(posedge clk) disable iff (!n_rst)
        rob_full && !rollback |=> !empty)
        else begin
            fail_count++;
            $error("reorder buffer went from full to empty without a rollback");
        end

    // A rollback only shrinks the live range.
    head_behind_tail: assert property (@(posedge clk) disable iff (!n_rst)
        rollback |=> count <= $past(count))
        else begin
            fail_count++;
            $error("rollback moved the tail past the head");
        end

    completion_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        completion.valid |-> rob_pkg::rob_in_range(active_range, completion.rob_addr))
        else begin
            fail_count++;
            $error("completion names a slot outside the active range");
        end

endmodule

bind reorder_buffer rename_checker chk_i (
    .clk          (clk),
    .n_rst        (n_rst),
    .rollback     (rollback),
    .rob_full     (rob_full),
    .empty        (empty),
    .count        (count),
    .completion   (completion),
    .active_range (active_range)
);

//--- rename_scoreboard.sv
`timescale 1ns/1ps

module rename_scoreboard (
    input  logic                    clk,
    input  logic                    n_rst,
    input  rename_pkg::dec_instr_t  instr,
    input  logic                    rollback,
    input  logic                    stall,
    input  rob_pkg::rob_addr_t      rob_open_slot,
    input  rename_pkg::rename_out_t renamed,
    input  rename_pkg::reg_return_t checkin,
    input  rob_pkg::rob_range_t     active_range,
    input  logic                    exp_stall,
    input  rename_pkg::rename_out_t exp_renamed,
    input  rename_pkg::reg_return_t exp_checkin,
    input  rob_pkg::rob_addr_t      m_head,
    input  rob_pkg::rob_addr_t      m_tail,
    output int                      error_count
);

    initial error_count = 0;

    task automatic compare_value(string name, logic [47:0] expected, logic [47:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (n_rst) begin
            if (!instr.valid || exp_stall) begin
                compare_value("stall", 48'(exp_stall), 48'(stall));
            end
            if (instr.valid && !stall && !rollback) begin
                compare_value("renamed.new_rw", 48'(exp_renamed.new_rw), 48'(renamed.new_rw));
                compare_value("renamed.prev_rw", 48'(exp_renamed.prev_rw), 48'(renamed.prev_rw));
                compare_value("renamed.new_rs", 48'(exp_renamed.new_rs), 48'(renamed.new_rs));
                compare_value("renamed.prev_rs", 48'(exp_renamed.prev_rs), 48'(renamed.prev_rs));
            end
            compare_value("rob_open_slot", 48'(m_tail), 48'(rob_open_slot));
            compare_value("checkin", exp_checkin, checkin);
            compare_value("active_range.high", 48'(m_tail), 48'(active_range.high));
            compare_value("active_range.empty", 48'(m_tail == active_range.low),
                          48'(active_range.empty));
            if (active_range.low != m_head && active_range.low != m_head + 1'b1) begin
                error_count++;
                $display("Head jumped by more than one slot at %0t", $time);
            end
            if (active_range.low != m_head && m_head == m_tail) begin
                error_count++;
                $display("A slot retired that is not live in the model at %0t", $time);
            end
        end
    end

endmodule

//--- tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core;

    typedef struct packed {
        logic                    use_rw;
        logic                    use_rs;
        rename_pkg::d_arch_t     rw_arch;
        rename_pkg::s_arch_t     rs_arch;
        rename_pkg::rename_out_t regs;
    } model_entry_t;

    typedef struct packed {
        rename_pkg::dec_instr_t instr;
        logic                   rollback;
        rob_pkg::rob_addr_t     offset;
    } stim_row_t;

    logic                    clk = 1'b0;
    logic                    n_rst;
    rename_pkg::dec_instr_t  instr;
    logic                    rollback;
    rob_pkg::rob_addr_t      incident_addr;
    logic                    stall;
    rob_pkg::rob_addr_t      rob_open_slot;
    rename_pkg::rename_out_t renamed;
    rename_pkg::reg_return_t checkin;
    rob_pkg::rob_range_t     active_range;

    rename_pkg::d_phys_t [rename_pkg::NUM_ARCH_D-1:0] m_map_d;   // Reference model.
    rename_pkg::s_phys_t [rename_pkg::NUM_ARCH_S-1:0] m_map_s;
    logic [rename_pkg::NUM_D_REG-1:0]                 m_d_free;
    logic [rename_pkg::NUM_S_REG-1:0]                 m_s_free;
    model_entry_t                                     m_entry [rob_pkg::ROB_SIZE];
    rob_pkg::rob_addr_t                               m_head;
    rob_pkg::rob_addr_t                               m_tail;
    rename_pkg::reg_return_t                          m_squash_ret;

    logic                    retired;
    rob_pkg::rob_addr_t      eff_head;
    logic                    exp_full;
    logic                    exp_stall;
    logic                    push;
    rename_pkg::rename_out_t exp_renamed;
    rename_pkg::reg_return_t exp_checkin;
    stim_row_t               stim_q [$];
    int                      timeouts;
    int                      errors;

    always #10 clk = ~clk;

    rename_core #(.ALU_LATENCY(2), .MEM_LATENCY(4)) dut_i (
        .clk (clk), .n_rst (n_rst), .instr (instr), .rollback (rollback),
        .incident_addr (incident_addr), .stall (stall), .rob_open_slot (rob_open_slot),
        .renamed (renamed), .checkin (checkin), .active_range (active_range)
    );

    rename_scoreboard sb_i (
        .clk (clk), .n_rst (n_rst), .instr (instr), .rollback (rollback), .stall (stall),
        .rob_open_slot (rob_open_slot), .renamed (renamed), .checkin (checkin),
        .active_range (active_range), .exp_stall (exp_stall), .exp_renamed (exp_renamed),
        .exp_checkin (exp_checkin), .m_head (m_head), .m_tail (m_tail), .error_count (errors)
    );

    function automatic int lowest_set(logic [31:0] bits);
        for (int i = 0; i < 32; i++) begin
            if (bits[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic rename_pkg::dec_instr_t make_instr(logic use_rw, int rw, logic use_rs,
                                                          int rs, logic unit);
        rename_pkg::dec_instr_t d;
        d.valid   = 1'b1;
        d.use_rw  = use_rw;
        d.rw_arch = rename_pkg::d_arch_t'(rw);
        d.use_rs  = use_rs;
        d.rs_arch = rename_pkg::s_arch_t'(rs);
        d.unit    = unit;
        return d;
    endfunction

    task automatic add_row(rename_pkg::dec_instr_t i, logic rb, int offset);
        stim_row_t row;
        row.instr    = i;
        row.rollback = rb;
        row.offset   = rob_pkg::rob_addr_t'(offset);
        stim_q.push_back(row);
    endtask

    always_comb begin
        retired   = (active_range.low != m_head);   // Head moved at the last edge.
        eff_head  = retired ? m_head + 1'b1 : m_head;
        exp_full  = ((m_tail - eff_head) == rob_pkg::rob_addr_t'(rob_pkg::ROB_SIZE - 1));
        exp_stall = exp_full || (instr.valid && ((instr.use_rw && m_d_free == '0)
                    || (instr.use_rs && m_s_free == '0)));
        exp_renamed.new_rw  = rename_pkg::d_phys_t'(lowest_set(m_d_free));
        exp_renamed.prev_rw = m_map_d[instr.rw_arch];
        exp_renamed.new_rs  = rename_pkg::s_phys_t'(lowest_set({16'b0, m_s_free}));
        exp_renamed.prev_rs = m_map_s[instr.rs_arch];
        exp_checkin = m_squash_ret;
        if (retired && m_entry[m_head].use_rw) begin
            exp_checkin.r_list[m_entry[m_head].regs.prev_rw] = 1'b1;
        end
        if (retired && m_entry[m_head].use_rs) begin
            exp_checkin.s_list[m_entry[m_head].regs.prev_rs] = 1'b1;
        end
    end

    assign push = instr.valid && !stall && !rollback;

    always @(posedge clk) begin
        model_entry_t                                     e;
        rename_pkg::reg_return_t                          squash;
        rename_pkg::d_phys_t [rename_pkg::NUM_ARCH_D-1:0] map_d;
        rename_pkg::s_phys_t [rename_pkg::NUM_ARCH_S-1:0] map_s;
        logic [rename_pkg::NUM_D_REG-1:0]                 d_free;
        logic [rename_pkg::NUM_S_REG-1:0]                 s_free;
        int                                               n;
        if (!n_rst) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH_D; i++) begin
                m_map_d[i] <= rename_pkg::d_phys_t'(i);
            end
            for (int i = 0; i < rename_pkg::NUM_ARCH_S; i++) begin
                m_map_s[i] <= rename_pkg::s_phys_t'(i);
            end
            m_d_free     <= {rename_pkg::NUM_D_REG{1'b1}} << rename_pkg::NUM_ARCH_D;
            m_s_free     <= {rename_pkg::NUM_S_REG{1'b1}} << rename_pkg::NUM_ARCH_S;
            m_head       <= '0;
            m_tail       <= '0;
            m_squash_ret <= '0;
        end else begin
            map_d  = m_map_d;
            map_s  = m_map_s;
            d_free = m_d_free | exp_checkin.r_list;
            s_free = m_s_free | exp_checkin.s_list;
            squash = '0;
            if (rollback) begin
                n = int'(rob_pkg::rob_addr_t'(m_tail - incident_addr - 1'b1));
                for (int k = 1; k <= n; k++) begin   // Undo youngest first.
                    e = m_entry[rob_pkg::rob_addr_t'(m_tail - k)];
                    if (e.use_rw) begin
                        map_d[e.rw_arch] = e.regs.prev_rw;
                        squash.r_list[e.regs.new_rw] = 1'b1;
                    end
                    if (e.use_rs) begin
                        map_s[e.rs_arch] = e.regs.prev_rs;
                        squash.s_list[e.regs.new_rs] = 1'b1;
                    end
                end
                m_tail <= incident_addr + 1'b1;
            end else if (push) begin
                e = '{use_rw: instr.use_rw, use_rs: instr.use_rs, rw_arch: instr.rw_arch,
                      rs_arch: instr.rs_arch, regs: exp_renamed};
                if (instr.use_rw) begin
                    map_d[instr.rw_arch] = exp_renamed.new_rw;
                    d_free[exp_renamed.new_rw] = 1'b0;
                end
                if (instr.use_rs) begin
                    map_s[instr.rs_arch] = exp_renamed.new_rs;
                    s_free[exp_renamed.new_rs] = 1'b0;
                end
                m_entry[m_tail] <= e;
                m_tail <= m_tail + 1'b1;
            end
            m_head       <= eff_head;
            m_map_d      <= map_d;
            m_map_s      <= map_s;
            m_d_free     <= d_free;
            m_s_free     <= s_free;
            m_squash_ret <= squash;
        end
    end

    initial begin
        stim_row_t   row;
        logic [31:0] r;
        int          tries;
        int          count;
        int          total;
        void'($urandom(32'hf6a1a323));
        instr         = '0;
        rollback      = 1'b0;
        incident_addr = '0;
        n_rst         = 1'b0;
        timeouts      = 0;
        add_row(make_instr(1, 1, 0, 0, 0), 0, 0);
        add_row(make_instr(1, 1, 1, 2, 0), 0, 0);
        add_row(make_instr(1, 3, 0, 0, 1), 0, 0);
        add_row(make_instr(1, 4, 1, 3, 0), 0, 0);   // Younger ALU op finishes first.
        add_row(make_instr(1, 5, 1, 1, 1), 0, 0);
        add_row('0, 0, 0);
        add_row(make_instr(1, 6, 0, 0, 0), 0, 0);   // Same-cycle finish with the memory op.
        for (int i = 0; i < 24; i++) begin
            add_row(make_instr(1, i % 8, 1, i % 4, 1), 0, 0);
        end
        add_row('0, 1, 3);
        add_row(make_instr(1, 2, 1, 0, 0), 0, 0);
        for (int i = 0; i < 80; i++) begin
            r = $urandom;
            if (r[2:0] == 3'd0) begin
                add_row('0, 1, int'(r[7:4]));
            end else begin
                add_row(make_instr(r[8], int'(r[11:9]), r[12], int'(r[14:13]), r[15]), 0, 0);
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        foreach (stim_q[idx]) begin
            row   = stim_q[idx];
            count = int'(rob_pkg::rob_addr_t'(m_tail - m_head));
            if (row.rollback) begin
                if (count >= 2) begin   // Incident lies strictly after the head.
                    rollback      = 1'b1;
                    incident_addr = m_head + 1'b1 + rob_pkg::rob_addr_t'(row.offset % (count - 1));
                end
                @(negedge clk);
                rollback = 1'b0;
            end else begin
                instr = row.instr;
                tries = 0;
                do begin
                    @(posedge clk);
                    tries++;
                end while (instr.valid && stall && tries < 100);
                if (instr.valid && stall) begin
                    timeouts++;
                    $display("Row %0d was not accepted within 100 cycles", idx);
                    break;
                end
                @(negedge clk);
                instr = '0;
            end
        end
        tries = 0;
        while (timeouts == 0 && (m_head != m_tail || !active_range.empty) && tries < 200) begin
            @(negedge clk);
            tries++;
        end
        if (tries >= 200) begin
            timeouts++;
            $display("Reorder buffer did not drain within 200 cycles");
        end
        repeat (2) @(negedge clk);
        total = errors + timeouts + dut_i.rob_i.chk_i.fail_count;
        $display("Compare errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, dut_i.rob_i.chk_i.fail_count);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim.f
rename_pkg.sv
rob_pkg.sv
free_reg_list.sv
translation_table.sv
reorder_buffer.sv
exec_pipe.sv
completion_arbiter.sv
rename_core.sv
rename_checker.sv
rename_scoreboard.sv
tb_rename_core.sv

//--- Bender.yml
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - rob_pkg.sv
  - free_reg_list.sv
  - translation_table.sv
  - reorder_buffer.sv
  - exec_pipe.sv
  - completion_arbiter.sv
  - rename_core.sv
  - target: test
    files:
      - rename_checker.sv
      - rename_scoreboard.sv
      - tb_rename_core.sv
